/* build.f */
+incdir+verilog
verilog/pair_map_pkg.sv
verilog/pm_pipe_reg.sv
verilog/pm_pair_table.sv
verilog/pair_map.sv
sim/tb_pair_map.sv

/* run_sim.sh */
#!/bin/sh
# Builds the pair map testbench with Verilator and runs it.
# The run passes only when the simulation prints its pass line.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f build.f --top-module tb_pair_map -o sim_pair_map; then
    echo "verilator build failed"
    exit 1
fi

if [ ! -x ./obj_dir/sim_pair_map ]; then
    echo "simulation binary missing"
    exit 1
fi

output=$(./obj_dir/sim_pair_map)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
    exit 0
else
    echo "simulation did not report a pass"
    exit 1
fi

/* sim/tb_pair_map.sv */
/*
 * tb_pair_map
 * drives scripted and random commands into the pair map under random back-pressure
 * and checks every response in order against a reference model
 */
`timescale 1ns/1ns
`include "pair_map_consts.svh"

module tb_pair_map;

    import pair_map_pkg::*;

    localparam int N_RANDOM = 400;

    logic       clock;
    logic       rst_n;
    logic       cmd_valid;
    logic       cmd_ready;
    pm_op_e     cmd_op;
    pm_key_t    cmd_key;
    pm_val_t    cmd_val;
    logic       resp_valid;
    logic       resp_ready;
    pm_op_e     resp_op;
    pm_status_e resp_status;
    pm_key_t    resp_key;
    pm_val_t    resp_val;

    pm_cmd_t    cmd_list[$];    // everything to send in order
    int         gap_list[$];    // idle cycles before each command
    pm_resp_t   exp_q[$];       // expected responses with the oldest first
    int         n_cmds     = 0;
    int         resp_count = 0;

    // model of the table contents
    pm_key_t    m_key [`PM_ENTRIES];
    pm_val_t    m_val [`PM_ENTRIES];
    bit         m_vld [`PM_ENTRIES];

    pair_map u_pair_map (
        .clock       (clock),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_op      (cmd_op),
        .cmd_key     (cmd_key),
        .cmd_val     (cmd_val),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_op     (resp_op),
        .resp_status (resp_status),
        .resp_key    (resp_key),
        .resp_val    (resp_val)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // expected response per the table rules and the matching model update
    function automatic pm_resp_t pm_model_step(input pm_cmd_t c);
        pm_resp_t r;
        int       hit;
        int       free_idx;
        bit       cleared;
        r.op     = c.op;
        r.status = PM_OK;
        r.key    = c.key;
        r.val    = c.val;
        hit      = -1;
        free_idx = -1;
        cleared  = 1'b0;
        case (c.op)
            PM_WRITE: begin
                for (int i = 0; i < `PM_ENTRIES; i++) begin
                    if (hit < 0 && m_vld[i] && m_key[i] == c.key) hit = i;
                    if (free_idx < 0 && !m_vld[i]) free_idx = i;
                end
                if (hit >= 0) begin
                    m_val[hit] = c.val;
                end else if (free_idx >= 0) begin
                    m_vld[free_idx] = 1'b1;
                    m_key[free_idx] = c.key;
                    m_val[free_idx] = c.val;
                end else begin
                    r.status = PM_FULL;     // table untouched
                end
            end
            PM_DEL_KEY, PM_DEL_VAL: begin
                for (int i = 0; i < `PM_ENTRIES; i++) begin
                    if (m_vld[i] && ((c.op == PM_DEL_KEY) ? (m_key[i] == c.key)
                                                          : (m_val[i] == c.val))) begin
                        m_vld[i] = 1'b0;
                        cleared  = 1'b1;
                    end
                end
                r.status = cleared ? PM_OK : PM_MISS;
            end
            PM_READ_KEY: begin
                for (int i = `PM_ENTRIES - 1; i >= 0; i--) begin
                    if (m_vld[i] && m_key[i] == c.key) hit = i;
                end
                r.status = (hit >= 0) ? PM_HIT : PM_MISS;
                r.val    = (hit >= 0) ? m_val[hit] : '0;
            end
            PM_READ_VAL: begin
                for (int i = `PM_ENTRIES - 1; i >= 0; i--) begin
                    if (m_vld[i] && m_val[i] == c.val) hit = i;    // lowest slot last
                end
                r.status = (hit >= 0) ? PM_HIT : PM_MISS;
                r.key    = (hit >= 0) ? m_key[hit] : '0;
            end
            default: r.status = PM_MISS;    // never generated
        endcase
        return r;
    endfunction

    task automatic add_cmd(input pm_op_e op, input pm_key_t key, input pm_val_t val,
                           input int gap);
        pm_cmd_t c;
        c.op  = op;
        c.key = key;
        c.val = val;
        cmd_list.push_back(c);
        gap_list.push_back(gap);
    endtask

    task automatic build_script();
        // lookups both ways and an absent key
        add_cmd(PM_WRITE,    8'h10, 8'ha1, 0);
        add_cmd(PM_READ_KEY, 8'h10, 8'h00, 0);
        add_cmd(PM_READ_VAL, 8'h00, 8'ha1, 0);
        add_cmd(PM_READ_KEY, 8'h33, 8'h5e, 0);
        // overwrite and a shared value
        add_cmd(PM_WRITE,    8'h10, 8'hb2, 0);
        add_cmd(PM_READ_KEY, 8'h10, 8'h00, 0);
        add_cmd(PM_WRITE,    8'h20, 8'hc3, 0);
        add_cmd(PM_WRITE,    8'h21, 8'hc3, 1);
        add_cmd(PM_READ_VAL, 8'h00, 8'hc3, 0);
        // deletes and the misses after them
        add_cmd(PM_DEL_KEY,  8'h20, 8'h00, 0);
        add_cmd(PM_READ_KEY, 8'h20, 8'h00, 0);
        add_cmd(PM_DEL_VAL,  8'h00, 8'hc3, 0);
        add_cmd(PM_READ_VAL, 8'h00, 8'hc3, 2);
        add_cmd(PM_DEL_KEY,  8'h55, 8'h00, 0);
        add_cmd(PM_DEL_VAL,  8'h00, 8'h77, 0);
        // fill every slot and write one too many
        for (int i = 0; i < `PM_ENTRIES - 1; i++) begin
            add_cmd(PM_WRITE, pm_key_t'(8'h40 + i), pm_val_t'(8'h80 + i), 0);
        end
        add_cmd(PM_WRITE,    8'h50, 8'h99, 0);
        add_cmd(PM_READ_KEY, 8'h50, 8'h00, 0);
        add_cmd(PM_READ_VAL, 8'h00, 8'h99, 0);
        add_cmd(PM_WRITE,    8'h43, 8'h9a, 0);     // overwrite while full
        add_cmd(PM_READ_KEY, 8'h43, 8'h00, 0);
        // empty the table again
        add_cmd(PM_DEL_KEY,  8'h10, 8'h00, 0);
        for (int i = 0; i < `PM_ENTRIES - 1; i++) begin
            add_cmd(PM_DEL_KEY, pm_key_t'(8'h40 + i), 8'h00, 0);
        end
    endtask

    // small key and value ranges so duplicates, hits and full all happen
    task automatic build_random();
        pm_op_e op;
        int     pick;
        int     gap;
        for (int n = 0; n < N_RANDOM; n++) begin
            pick = int'($urandom % 10);
            case (pick)
                0, 1, 2, 3: op = PM_WRITE;
                4:          op = PM_DEL_KEY;
                5:          op = PM_DEL_VAL;
                6, 7:       op = PM_READ_KEY;
                default:    op = PM_READ_VAL;
            endcase
            gap = (($urandom % 8) == 0) ? int'(1 + ($urandom % 2)) : 0;
            add_cmd(op, pm_key_t'($urandom % 12), pm_val_t'($urandom % 6), gap);
        end
    endtask

    // holds the command until the DUT takes it
    task automatic drive_cmd(input pm_cmd_t c);
        cmd_valid <= 1'b1;
        cmd_op    <= c.op;
        cmd_key   <= c.key;
        cmd_val   <= c.val;
        @(posedge clock);
        while (!cmd_ready) begin
            @(posedge clock);
        end
    endtask

    task automatic check_op(input pm_op_e exp, input pm_op_e act);
        if (exp !== act) begin
            abort_run($sformatf("[ERROR] %0t resp_op expected %s (%0d) got %s (%0d)",
                                $time, exp.name(), exp, act.name(), act));
        end
    endtask

    task automatic check_status(input pm_status_e exp, input pm_status_e act);
        if (exp !== act) begin
            abort_run($sformatf("[ERROR] %0t resp_status expected %s (%0d) got %s (%0d)",
                                $time, exp.name(), exp, act.name(), act));
        end
    endtask

    task automatic check_key(input pm_key_t exp, input pm_key_t act);
        if (exp !== act) begin
            abort_run($sformatf("[ERROR] %0t resp_key expected 0x%02h got 0x%02h",
                                $time, exp, act));
        end
    endtask

    task automatic check_val(input pm_val_t exp, input pm_val_t act);
        if (exp !== act) begin
            abort_run($sformatf("[ERROR] %0t resp_val expected 0x%02h got 0x%02h",
                                $time, exp, act));
        end
    endtask

    // model steps at the accepting edge
    always @(posedge clock) begin
        if (rst_n && cmd_valid && cmd_ready) begin
            exp_q.push_back(pm_model_step({cmd_op, cmd_key, cmd_val}));
        end
    end

    // compare each response transfer with the oldest expected one
    always @(posedge clock) begin
        pm_resp_t exp;
        if (rst_n && resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("a response arrived with no command outstanding");
            end
            exp = exp_q.pop_front();
            check_op(exp.op, resp_op);
            check_status(exp.status, resp_status);
            check_key(exp.key, resp_key);
            check_val(exp.val, resp_val);
            resp_count <= resp_count + 1;
        end
    end

    always @(posedge clock) begin
        resp_ready <= (($urandom % 4) != 0);   // ready about 3 cycles in 4
    end

    initial begin
        wait (n_cmds > 0);
        repeat (n_cmds * 20 + 50) @(posedge clock);
        abort_run("timeout: the responses did not all arrive in time");
    end

    initial begin
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd_op     = PM_WRITE;
        cmd_key    = '0;
        cmd_val    = '0;
        resp_ready = 1'b0;
        for (int i = 0; i < `PM_ENTRIES; i++) begin
            m_vld[i] = 1'b0;
            m_key[i] = '0;
            m_val[i] = '0;
        end
        void'($urandom(32'hbcd321d3));
        build_script();
        build_random();
        n_cmds = cmd_list.size();

        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
        @(posedge clock);

        for (int i = 0; i < n_cmds; i++) begin
            repeat (gap_list[i]) begin
                cmd_valid <= 1'b0;
                @(posedge clock);
            end
            drive_cmd(cmd_list[i]);
        end
        cmd_valid <= 1'b0;

        wait (resp_count == n_cmds);
        repeat (10) @(posedge clock);  // catch any extra response
        if (resp_count == n_cmds && exp_q.size() == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            abort_run("the number of responses differs from the number of commands");
        end
    end

endmodule

/* verilog/pair_map.sv */
/*
 * pair_map top
 * input slice, pair table and output slice in one valid/ready chain
 */
`timescale 1ns/1ns

module pair_map (
    input  logic                     clock,
    input  logic                     rst_n,

    // command stream
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    input  pair_map_pkg::pm_op_e     cmd_op,
    input  pair_map_pkg::pm_key_t    cmd_key,
    input  pair_map_pkg::pm_val_t    cmd_val,

    // response stream
    output logic                     resp_valid,
    input  logic                     resp_ready,
    output pair_map_pkg::pm_op_e     resp_op,
    output pair_map_pkg::pm_status_e resp_status,
    output pair_map_pkg::pm_key_t    resp_key,
    output pair_map_pkg::pm_val_t    resp_val
);

    import pair_map_pkg::*;

    pm_cmd_t  cmd_in;       // packed from ports
    pm_cmd_t  cmd_q;        // input slice output
    pm_resp_t resp_d;       // packed from table outputs
    pm_resp_t resp_q;

    logic     tbl_in_valid;
    logic     tbl_in_ready;
    logic     tbl_out_valid;
    logic     tbl_out_ready;

    assign cmd_in.op  = cmd_op;
    assign cmd_in.key = cmd_key;
    assign cmd_in.val = cmd_val;

    pm_pipe_reg #(
        .data_t    (pm_cmd_t)
    ) u_cmd_reg (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (cmd_valid),
        .in_ready  (cmd_ready),
        .in_data   (cmd_in),
        .out_valid (tbl_in_valid),
        .out_ready (tbl_in_ready),
        .out_data  (cmd_q)
    );

    pm_pair_table u_table (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_valid   (tbl_in_valid),
        .in_ready   (tbl_in_ready),
        .in_op      (cmd_q.op),
        .in_key     (cmd_q.key),
        .in_val     (cmd_q.val),
        .out_valid  (tbl_out_valid),
        .out_ready  (tbl_out_ready),
        .out_op     (resp_d.op),
        .out_status (resp_d.status),
        .out_key    (resp_d.key),
        .out_val    (resp_d.val)
    );

    pm_pipe_reg #(
        .data_t    (pm_resp_t)
    ) u_resp_reg (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (tbl_out_valid),
        .in_ready  (tbl_out_ready),
        .in_data   (resp_d),
        .out_valid (resp_valid),
        .out_ready (resp_ready),
        .out_data  (resp_q)
    );

    // unpack to the loose response ports
    assign resp_op     = resp_q.op;
    assign resp_status = resp_q.status;
    assign resp_key    = resp_q.key;
    assign resp_val    = resp_q.val;

endmodule

/* verilog/pair_map_consts.svh */
/*
 * pair map sizing constants
 * key and value widths plus the number of table slots
 */
`ifndef PAIR_MAP_CONSTS_SVH
`define PAIR_MAP_CONSTS_SVH

// key field width in bits
`define PM_KEY_W    8

// value field width in bits
`define PM_VAL_W    8

// number of key/value slots in the table
`define PM_ENTRIES  8

`endif

/* verilog/pair_map_pkg.sv */
/*
 * pair map shared types
 * opcodes, response status and the command/response payloads
 */
`include "pair_map_consts.svh"

package pair_map_pkg;

    typedef logic [`PM_KEY_W-1:0] pm_key_t;
    typedef logic [`PM_VAL_W-1:0] pm_val_t;

    typedef enum logic [2:0] {
        PM_WRITE    = 3'd0,
        PM_DEL_KEY  = 3'd1,
        PM_DEL_VAL  = 3'd2,
        PM_READ_KEY = 3'd3,     // forward lookup
        PM_READ_VAL = 3'd4      // reverse lookup
    } pm_op_e;

    typedef enum logic [1:0] {
        PM_OK   = 2'd0,
        PM_HIT  = 2'd1,
        PM_MISS = 2'd2,
        PM_FULL = 2'd3
    } pm_status_e;

    // command into the input slice
    typedef struct packed {
        pm_op_e  op;
        pm_key_t key;
        pm_val_t val;
    } pm_cmd_t;

    typedef struct packed {
        pm_op_e     op;
        pm_status_e status;
        pm_key_t    key;
        pm_val_t    val;
    } pm_resp_t;

endpackage

/* verilog/pm_pair_table.sv */
/*
 * pm_pair_table
 * key/value slot storage with key, value and free-slot search
 * executes one command per accepted transfer and registers the response
 */
`timescale 1ns/1ns
`include "pair_map_consts.svh"

module pm_pair_table (
    input  logic                    clock,
    input  logic                    rst_n,

    // command side
    input  logic                    in_valid,
    output logic                    in_ready,
    input  pair_map_pkg::pm_op_e    in_op,
    input  pair_map_pkg::pm_key_t   in_key,
    input  pair_map_pkg::pm_val_t   in_val,

    // response side
    output logic                    out_valid,
    input  logic                    out_ready,
    output pair_map_pkg::pm_op_e    out_op,
    output pair_map_pkg::pm_status_e out_status,
    output pair_map_pkg::pm_key_t   out_key,
    output pair_map_pkg::pm_val_t   out_val
);

    import pair_map_pkg::*;

    localparam int IDX_W = (`PM_ENTRIES > 1) ? $clog2(`PM_ENTRIES) : 1;

    // slot storage
    pm_key_t                key_q [`PM_ENTRIES];
    pm_val_t                val_q [`PM_ENTRIES];
    logic [`PM_ENTRIES-1:0] vld_q;

    // search results
    logic [`PM_ENTRIES-1:0] key_match;
    logic [`PM_ENTRIES-1:0] val_match;
    logic [`PM_ENTRIES-1:0] free_slot;
    logic [IDX_W-1:0]       key_idx;
    logic [IDX_W-1:0]       val_idx;
    logic [IDX_W-1:0]       free_idx;
    logic                   key_hit;
    logic                   val_hit;
    logic                   free_any;

    // command decode
    logic                   fire;
    logic                   wr_en;
    logic [IDX_W-1:0]       wr_idx;
    logic [`PM_ENTRIES-1:0] wr_mask;
    logic [`PM_ENTRIES-1:0] clr_mask;
    logic [`PM_ENTRIES-1:0] vld_nxt;
    pm_status_e             rsp_status;
    pm_key_t                rsp_key;
    pm_val_t                rsp_val;

    // response holds until taken downstream
    assign in_ready = !out_valid || out_ready;
    assign fire     = in_valid && in_ready;

    // per-slot compares where only valid slots can match
    always_comb begin
        for (int i = 0; i < `PM_ENTRIES; i++) begin
            key_match[i] = vld_q[i] && (key_q[i] == in_key);
            val_match[i] = vld_q[i] && (val_q[i] == in_val);
            free_slot[i] = !vld_q[i];
        end
    end

    assign key_hit  = |key_match;
    assign val_hit  = |val_match;
    assign free_any = |free_slot;

    // scan from the top down so the lowest index wins
    always_comb begin
        key_idx  = '0;
        val_idx  = '0;
        free_idx = '0;
        for (int i = `PM_ENTRIES - 1; i >= 0; i--) begin
            if (key_match[i]) begin
                key_idx = IDX_W'(i);
            end
            if (val_match[i]) begin
                val_idx = IDX_W'(i);
            end
            if (free_slot[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    // table rules
    always_comb begin
        wr_en      = 1'b0;
        wr_idx     = '0;
        clr_mask   = '0;
        rsp_status = PM_OK;
        rsp_key    = in_key;   // echo by default
        rsp_val    = in_val;

        case (in_op)
            PM_WRITE: begin
                if (key_hit) begin
                    wr_en  = 1'b1;          // overwrite in place
                    wr_idx = key_idx;
                end else if (free_any) begin
                    wr_en  = 1'b1;
                    wr_idx = free_idx;
                end else begin
                    rsp_status = PM_FULL;
                end
            end
            PM_DEL_KEY: begin
                clr_mask   = key_match;
                rsp_status = key_hit ? PM_OK : PM_MISS;
            end
            PM_DEL_VAL: begin
                clr_mask   = val_match;     // may clear several slots
                rsp_status = val_hit ? PM_OK : PM_MISS;
            end
            PM_READ_KEY: begin
                if (key_hit) begin
                    rsp_status = PM_HIT;
                    rsp_val    = val_q[key_idx];
                end else begin
                    rsp_status = PM_MISS;
                    rsp_val    = '0;
                end
            end
            PM_READ_VAL: begin
                if (val_hit) begin
                    rsp_status = PM_HIT;
                    rsp_key    = key_q[val_idx];
                end else begin
                    rsp_status = PM_MISS;
                    rsp_key    = '0;
                end
            end
            default: begin
                rsp_status = PM_MISS;       // unknown opcode leaves the state alone
            end
        endcase
    end

    // next valid bits
    always_comb begin
        wr_mask = '0;
        if (wr_en) begin
            wr_mask[wr_idx] = 1'b1;
        end
        vld_nxt = (vld_q & ~clr_mask) | wr_mask;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            vld_q     <= '0;    // table empty
            out_valid <= 1'b0;
        end else begin
            if (fire) begin
                vld_q <= vld_nxt;
            end
            if (in_ready) begin
                out_valid <= in_valid;
            end
        end
    end

    // slot contents
    always_ff @(posedge clock) begin
        if (fire && wr_en) begin
            key_q[wr_idx] <= in_key;
            val_q[wr_idx] <= in_val;
        end
    end

    // registered response
    always_ff @(posedge clock) begin
        if (fire) begin
            out_op     <= in_op;
            out_status <= rsp_status;
            out_key    <= rsp_key;
            out_val    <= rsp_val;
        end
    end

endmodule

/* verilog/pm_pipe_reg.sv */
/*
 * pm_pipe_reg
 * one-entry valid/ready register slice with its payload type set by data_t
 * full throughput when the downstream side keeps taking data
 */
`timescale 1ns/1ns

module pm_pipe_reg #(
    parameter type data_t = pair_map_pkg::pm_cmd_t
) (
    input  logic  clock,
    input  logic  rst_n,

    // upstream side
    input  logic  in_valid,
    output logic  in_ready,
    input  data_t in_data,

    // downstream side
    output logic  out_valid,
    input  logic  out_ready,
    output data_t out_data
);

    logic  full_q;      // slot occupied
    data_t data_q;      // held payload
    logic  load;

    // accept when empty, or when the held item leaves this same edge
    assign in_ready = !full_q || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (in_ready) begin
            // either refilled by a new item or drained
            full_q <= in_valid;
        end
    end

    // payload register
    always_ff @(posedge clock) begin
        if (load) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full_q;
    assign out_data  = data_q;

endmodule
